// ==== logic/tl_pkg.sv ====
package tl_pkg;

    // ========================================
    // Field widths of the A and D channels
    // ========================================
    localparam int xlen   = 32;        // Data and address width
    localparam int mask_w = xlen / 8;  // One bit per byte lane
    localparam int sid_w  = 8;         // Source id
    localparam int size_w = 3;         // log2 of the transfer size in bytes

    typedef logic [2:0] tl_opcode_t;

    // ========================================
    // Opcodes
    // ========================================

    // A channel requests
    localparam tl_opcode_t op_put_full    = 3'd0;
    localparam tl_opcode_t op_put_partial = 3'd1;
    localparam tl_opcode_t op_get         = 3'd4;

    // D channel responses
    localparam tl_opcode_t op_access_ack      = 3'd0;  // Ack for a put
    localparam tl_opcode_t op_access_ack_data = 3'd1;  // Ack with read data

endpackage

// ==== logic/soc_map_pkg.sv ====
package soc_map_pkg;

    // ========================================
    // Address map
    // ========================================

    // Data memory, 1 KiB
    localparam logic [31:0] mem_base = 32'h0000_0000;
    localparam logic [31:0] mem_mask = 32'h0000_03FF;

    // LED output register block
    localparam logic [31:0] out_base = 32'h0002_0000;
    localparam logic [31:0] out_mask = 32'h0000_000F;

    // ========================================
    // Target indices on the switch
    // ========================================
    localparam int tgt_mem     = 0;
    localparam int tgt_out     = 1;
    localparam int num_targets = 2;

endpackage

// ==== logic/tl_switch.sv ====
`timescale 1ns/10ps

module tl_switch (
    input  logic                                  CLK,
    input  logic                                  reset,

    // A channel from the master
    input  logic                                  a_valid,
    output logic                                  a_ready,
    input  tl_pkg::tl_opcode_t                    a_opcode,
    input  logic [tl_pkg::size_w-1:0]             a_size,
    input  logic [tl_pkg::sid_w-1:0]              a_source,
    input  logic [tl_pkg::xlen-1:0]               a_address,
    input  logic [tl_pkg::mask_w-1:0]             a_mask,
    input  logic [tl_pkg::xlen-1:0]               a_data,

    // D channel to the master
    input  logic                                  d_ready,
    output logic                                  d_valid,
    output tl_pkg::tl_opcode_t                    d_opcode,
    output logic [tl_pkg::size_w-1:0]             d_size,
    output logic [tl_pkg::sid_w-1:0]              d_source,
    output logic [tl_pkg::xlen-1:0]               d_data,
    output logic                                  d_denied,

    // Requests to the targets
    output logic [soc_map_pkg::num_targets-1:0]   tgt_req,
    output tl_pkg::tl_opcode_t                    tgt_opcode,
    output logic [tl_pkg::size_w-1:0]             tgt_size,
    output logic [tl_pkg::sid_w-1:0]              tgt_source,
    output logic [tl_pkg::xlen-1:0]               tgt_address,
    output logic [tl_pkg::mask_w-1:0]             tgt_mask,
    output logic [tl_pkg::xlen-1:0]               tgt_data,

    // Responses from the targets
    input  logic [soc_map_pkg::num_targets-1:0]   tgt_rsp_valid,
    input  tl_pkg::tl_opcode_t [soc_map_pkg::num_targets-1:0] tgt_rsp_opcode,
    input  logic [soc_map_pkg::num_targets-1:0][tl_pkg::xlen-1:0]   tgt_rsp_data,
    input  logic [soc_map_pkg::num_targets-1:0][tl_pkg::sid_w-1:0]  tgt_rsp_source,
    input  logic [soc_map_pkg::num_targets-1:0][tl_pkg::size_w-1:0] tgt_rsp_size,
    output logic [soc_map_pkg::num_targets-1:0]   tgt_rsp_ready
);

localparam int n_tgt = soc_map_pkg::num_targets;
localparam int sel_w = (n_tgt > 1) ? $clog2(n_tgt) : 1;

logic [n_tgt-1:0]  hit;
logic [sel_w-1:0]  hit_sel;
logic              hit_any;
logic              accept;

logic              busy;        // Response outstanding
logic              route_miss;  // Request matched no region
logic [sel_w-1:0]  route_sel;

// Locally generated denied response
logic                        den_valid;
tl_pkg::tl_opcode_t          den_opcode;
logic [tl_pkg::size_w-1:0]   den_size;
logic [tl_pkg::sid_w-1:0]    den_source;

// ========================================
// Address decode
// ========================================
always_comb begin
    hit = '0;
    hit[soc_map_pkg::tgt_mem] = (a_address & ~soc_map_pkg::mem_mask) == soc_map_pkg::mem_base;
    hit[soc_map_pkg::tgt_out] = (a_address & ~soc_map_pkg::out_mask) == soc_map_pkg::out_base;
end

// Lowest index wins, regions never overlap anyway
always_comb begin
    hit_sel = '0;
    hit_any = 1'b0;
    for (int i = n_tgt - 1; i >= 0; i--) begin
        if (hit[i]) begin
            hit_sel = i[sel_w-1:0];
            hit_any = 1'b1;
        end
    end
end

assign a_ready = ~busy;
assign accept  = a_valid & a_ready;

// Request fields go to every target, only the strobe is steered
always_comb begin
    tgt_req = '0;
    if (accept && hit_any) tgt_req[hit_sel] = 1'b1;
end

assign tgt_opcode  = a_opcode;
assign tgt_size    = a_size;
assign tgt_source  = a_source;
assign tgt_address = a_address;
assign tgt_mask    = a_mask;
assign tgt_data    = a_data;

// ========================================
// Route tracking, one request in flight
// ========================================
always_ff @(posedge CLK or posedge reset) begin
    if (reset) begin
        busy       <= 1'b0;
        route_miss <= 1'b0;
        route_sel  <= '0;
        den_valid  <= 1'b0;
    end else if (accept) begin
        busy       <= 1'b1;
        route_miss <= ~hit_any;
        route_sel  <= hit_sel;
        den_valid  <= ~hit_any;   // Denied answer ready next cycle
    end else if (d_valid && d_ready) begin
        busy      <= 1'b0;
        den_valid <= 1'b0;
    end
end

always_ff @(posedge CLK) begin
    if (accept) begin
        den_opcode <= (a_opcode == tl_pkg::op_get) ? tl_pkg::op_access_ack_data
                                                   : tl_pkg::op_access_ack;
        den_size   <= a_size;
        den_source <= a_source;
    end
end

// ========================================
// Response return
// ========================================
always_comb begin
    d_valid  = 1'b0;
    d_opcode = tl_pkg::op_access_ack;
    d_size   = '0;
    d_source = '0;
    d_data   = '0;
    d_denied = 1'b0;
    if (route_miss) begin
        d_valid  = den_valid;
        d_opcode = den_opcode;
        d_size   = den_size;
        d_source = den_source;
        d_denied = den_valid;     // Data stays zero
    end else if (busy && tgt_rsp_valid[route_sel]) begin
        d_valid  = 1'b1;
        d_opcode = tgt_rsp_opcode[route_sel];
        d_size   = tgt_rsp_size[route_sel];
        d_source = tgt_rsp_source[route_sel];
        d_data   = tgt_rsp_data[route_sel];
    end
end

always_comb begin
    for (int i = 0; i < n_tgt; i++) begin
        tgt_rsp_ready[i] = d_ready & busy & ~route_miss & (route_sel == i[sel_w-1:0]);
    end
end

endmodule

// ==== logic/tl_memory.sv ====
`timescale 1ns/10ps

module tl_memory #(
    parameter int mem_words = 256
) (
    input  logic                          CLK,
    input  logic                          reset,

    // Request from the switch
    input  logic                          req,
    input  tl_pkg::tl_opcode_t            opcode,
    input  logic [tl_pkg::size_w-1:0]     size,
    input  logic [tl_pkg::sid_w-1:0]      source,
    input  logic [tl_pkg::xlen-1:0]       address,
    input  logic [tl_pkg::mask_w-1:0]     mask,
    input  logic [tl_pkg::xlen-1:0]       data,

    // Response, held until taken
    output logic                          rsp_valid,
    output tl_pkg::tl_opcode_t            rsp_opcode,
    output logic [tl_pkg::size_w-1:0]     rsp_size,
    output logic [tl_pkg::sid_w-1:0]      rsp_source,
    output logic [tl_pkg::xlen-1:0]       rsp_data,
    input  logic                          rsp_ready
);

localparam int idx_w = (mem_words > 1) ? $clog2(mem_words) : 1;

logic [tl_pkg::xlen-1:0] mem [mem_words];
logic [idx_w-1:0]        idx;

assign idx = address[idx_w+1:2];  // Word index, byte offset dropped

// ========================================
// Response handshake
// ========================================
always_ff @(posedge CLK or posedge reset) begin
    if (reset) begin
        rsp_valid <= 1'b0;
    end else if (req) begin
        rsp_valid <= 1'b1;
    end else if (rsp_valid && rsp_ready) begin
        rsp_valid <= 1'b0;
    end
end

// ========================================
// Array access
// ========================================
always_ff @(posedge CLK) begin
    if (req) begin
        rsp_size   <= size;     // Echoed back
        rsp_source <= source;
        case (opcode)
            tl_pkg::op_get: begin
                rsp_opcode <= tl_pkg::op_access_ack_data;
                rsp_data   <= mem[idx];
            end
            tl_pkg::op_put_full, tl_pkg::op_put_partial: begin
                rsp_opcode <= tl_pkg::op_access_ack;
                rsp_data   <= '0;
                for (int b = 0; b < tl_pkg::mask_w; b++) begin
                    if (mask[b]) mem[idx][8*b +: 8] <= data[8*b +: 8];
                end
            end
            default: begin
                // Unsupported opcode, acked without side effect
                rsp_opcode <= tl_pkg::op_access_ack;
                rsp_data   <= '0;
            end
        endcase
    end
end

endmodule

// ==== logic/tl_output.sv ====
`timescale 1ns/10ps

module tl_output #(
    parameter int num_outputs = 4
) (
    input  logic                          CLK,
    input  logic                          reset,

    input  logic                          req,
    input  tl_pkg::tl_opcode_t            opcode,
    input  logic [tl_pkg::size_w-1:0]     size,
    input  logic [tl_pkg::sid_w-1:0]      source,
    input  logic [tl_pkg::xlen-1:0]       address,
    input  logic [tl_pkg::mask_w-1:0]     mask,
    input  logic [tl_pkg::xlen-1:0]       data,

    output logic                          rsp_valid,
    output tl_pkg::tl_opcode_t            rsp_opcode,
    output logic [tl_pkg::size_w-1:0]     rsp_size,
    output logic [tl_pkg::sid_w-1:0]      rsp_source,
    output logic [tl_pkg::xlen-1:0]       rsp_data,
    input  logic                          rsp_ready,

    output logic [num_outputs-1:0]        out
);

logic reg_sel;
logic is_write;

assign reg_sel  = (address[3:2] == 2'd0);  // Register lives at word 0
assign is_write = (opcode == tl_pkg::op_put_full) || (opcode == tl_pkg::op_put_partial);

// Output register, written through byte lane 0
always_ff @(posedge CLK or posedge reset) begin
    if (reset) begin
        out       <= '0;
        rsp_valid <= 1'b0;
    end else begin
        if (req && is_write && reg_sel && mask[0]) out <= data[num_outputs-1:0];
        if (req) rsp_valid <= 1'b1;
        else if (rsp_valid && rsp_ready) rsp_valid <= 1'b0;
    end
end

// Response payload
always_ff @(posedge CLK) begin
    if (req) begin
        rsp_size   <= size;
        rsp_source <= source;
        rsp_opcode <= is_write ? tl_pkg::op_access_ack : tl_pkg::op_access_ack_data;
        if (!is_write && reg_sel) rsp_data <= {{(tl_pkg::xlen - num_outputs){1'b0}}, out};
        else rsp_data <= '0;   // Other words read as zero
    end
end

endmodule

// ==== logic/blink_timer.sv ====
`timescale 1ns/10ps

module blink_timer #(
    parameter int half_period = 1000
) (
    input  logic CLK,
    input  logic reset,
    output logic blink
);

localparam int cnt_w = (half_period > 1) ? $clog2(half_period) : 1;
localparam logic [cnt_w-1:0] cnt_last = cnt_w'(half_period - 1);

logic [cnt_w-1:0] count;

// Free running, toggles once per half period
always_ff @(posedge CLK or posedge reset) begin
    if (reset) begin
        count <= '0;
        blink <= 1'b0;
    end else if (count == cnt_last) begin
        count <= '0;
        blink <= ~blink;
    end else begin
        count <= count + 1'b1;
    end
end

endmodule

// ==== logic/soc_top.sv ====
`timescale 1ns/10ps

module soc_top #(
    parameter int mem_words      = 256,
    parameter int num_outputs    = 4,
    parameter int heartbeat_half = 27_000_000,      // 1 s at 27 MHz
    parameter int slow_half      = heartbeat_half / 4
) (
    input  logic                          CLK,
    input  logic                          reset,

    // A channel
    input  logic                          a_valid,
    output logic                          a_ready,
    input  tl_pkg::tl_opcode_t            a_opcode,
    input  logic [tl_pkg::size_w-1:0]     a_size,
    input  logic [tl_pkg::sid_w-1:0]      a_source,
    input  logic [tl_pkg::xlen-1:0]       a_address,
    input  logic [tl_pkg::mask_w-1:0]     a_mask,
    input  logic [tl_pkg::xlen-1:0]       a_data,

    // D channel
    output logic                          d_valid,
    input  logic                          d_ready,
    output tl_pkg::tl_opcode_t            d_opcode,
    output logic [tl_pkg::size_w-1:0]     d_size,
    output logic [tl_pkg::sid_w-1:0]      d_source,
    output logic [tl_pkg::xlen-1:0]       d_data,
    output logic                          d_denied,

    output logic [5:0]                    led         // Active low
);

localparam int n_tgt = soc_map_pkg::num_targets;
localparam int i_mem = soc_map_pkg::tgt_mem;
localparam int i_out = soc_map_pkg::tgt_out;

// ========================================
// Switch to target wiring
// ========================================
wire [n_tgt-1:0]                      tgt_req;
tl_pkg::tl_opcode_t                   tgt_opcode;
wire [tl_pkg::size_w-1:0]             tgt_size;
wire [tl_pkg::sid_w-1:0]              tgt_source;
wire [tl_pkg::xlen-1:0]               tgt_address;
wire [tl_pkg::mask_w-1:0]             tgt_mask;
wire [tl_pkg::xlen-1:0]               tgt_data;

wire [n_tgt-1:0]                      rsp_valid;
wire [n_tgt-1:0][2:0]                 rsp_opcode;   // One opcode per target
wire [n_tgt-1:0][tl_pkg::xlen-1:0]    rsp_data;
wire [n_tgt-1:0][tl_pkg::sid_w-1:0]   rsp_source;
wire [n_tgt-1:0][tl_pkg::size_w-1:0]  rsp_size;
wire [n_tgt-1:0]                      rsp_ready;

wire [num_outputs-1:0]                out_bits;
wire                                  heartbeat;
wire                                  slow_toggle;

tl_switch i_switch (
    .CLK(CLK), .reset(reset),
    .a_valid(a_valid), .a_ready(a_ready), .a_opcode(a_opcode), .a_size(a_size),
    .a_source(a_source), .a_address(a_address), .a_mask(a_mask), .a_data(a_data),
    .d_ready(d_ready), .d_valid(d_valid), .d_opcode(d_opcode), .d_size(d_size),
    .d_source(d_source), .d_data(d_data), .d_denied(d_denied),
    .tgt_req(tgt_req), .tgt_opcode(tgt_opcode), .tgt_size(tgt_size),
    .tgt_source(tgt_source), .tgt_address(tgt_address), .tgt_mask(tgt_mask),
    .tgt_data(tgt_data),
    .tgt_rsp_valid(rsp_valid), .tgt_rsp_opcode(rsp_opcode), .tgt_rsp_data(rsp_data),
    .tgt_rsp_source(rsp_source), .tgt_rsp_size(rsp_size), .tgt_rsp_ready(rsp_ready)
);

// ========================================
// Targets
// ========================================
tl_memory #(.mem_words(mem_words)) i_memory (
    .CLK(CLK), .reset(reset),
    .req(tgt_req[i_mem]), .opcode(tgt_opcode), .size(tgt_size), .source(tgt_source),
    .address(tgt_address), .mask(tgt_mask), .data(tgt_data),
    .rsp_valid(rsp_valid[i_mem]), .rsp_opcode(rsp_opcode[i_mem]),
    .rsp_size(rsp_size[i_mem]), .rsp_source(rsp_source[i_mem]),
    .rsp_data(rsp_data[i_mem]), .rsp_ready(rsp_ready[i_mem])
);

tl_output #(.num_outputs(num_outputs)) i_output (
    .CLK(CLK), .reset(reset),
    .req(tgt_req[i_out]), .opcode(tgt_opcode), .size(tgt_size), .source(tgt_source),
    .address(tgt_address), .mask(tgt_mask), .data(tgt_data),
    .rsp_valid(rsp_valid[i_out]), .rsp_opcode(rsp_opcode[i_out]),
    .rsp_size(rsp_size[i_out]), .rsp_source(rsp_source[i_out]),
    .rsp_data(rsp_data[i_out]), .rsp_ready(rsp_ready[i_out]),
    .out(out_bits)
);

// ========================================
// Indicators and LED map
// ========================================
blink_timer #(.half_period(heartbeat_half)) i_heartbeat (
    .CLK(CLK), .reset(reset), .blink(heartbeat)
);

blink_timer #(.half_period(slow_half)) i_slow (
    .CLK(CLK), .reset(reset), .blink(slow_toggle)
);

assign led[3:0] = ~out_bits[3:0];   // Low four register bits
assign led[4]   = ~slow_toggle;
assign led[5]   = ~heartbeat;

endmodule

// ==== tests/soc_asserts.sv ====
`timescale 1ns/10ps

module soc_asserts (
    input logic                          CLK,
    input logic                          reset,
    input logic                          a_valid,
    input logic                          a_ready,
    input logic [tl_pkg::sid_w-1:0]      a_source,
    input logic                          d_valid,
    input logic                          d_ready,
    input tl_pkg::tl_opcode_t            d_opcode,
    input logic [tl_pkg::size_w-1:0]     d_size,
    input logic [tl_pkg::sid_w-1:0]      d_source,
    input logic [tl_pkg::xlen-1:0]       d_data,
    input logic                          d_denied
);

int                         fail_count = 0;
logic                       outstanding;   // Accepted, D not yet taken
logic [tl_pkg::sid_w-1:0]   req_source;
logic [46:0]                d_fields;

assign d_fields = {d_opcode, d_size, d_source, d_data, d_denied};

always_ff @(posedge CLK or posedge reset) begin
    if (reset) begin
        outstanding <= 1'b0;
        req_source  <= '0;
    end else if (a_valid && a_ready) begin
        outstanding <= 1'b1;
        req_source  <= a_source;
    end else if (d_valid && d_ready) begin
        outstanding <= 1'b0;
    end
end

// ========================================
// D channel rules
// ========================================
d_hold: assert property (@(posedge CLK) disable iff (reset)
    d_valid && !d_ready |=> d_valid && $stable(d_fields))
    else begin
        fail_count++;
        $error("D fields changed while stalled");
    end

d_one_cycle: assert property (@(posedge CLK) disable iff (reset)
    a_valid && a_ready |=> $rose(d_valid))
    else begin
        fail_count++;
        $error("d_valid did not rise one cycle after the A handshake");
    end

a_blocked: assert property (@(posedge CLK) disable iff (reset)
    outstanding |-> !a_ready)
    else begin
        fail_count++;
        $error("a_ready high with a response outstanding");
    end

d_source_match: assert property (@(posedge CLK) disable iff (reset)
    d_valid |-> d_source == req_source)
    else begin
        fail_count++;
        $error("d_source differs from the accepted request");
    end

endmodule

bind soc_top soc_asserts i_asserts (
    .CLK(CLK), .reset(reset),
    .a_valid(a_valid), .a_ready(a_ready), .a_source(a_source),
    .d_valid(d_valid), .d_ready(d_ready), .d_opcode(d_opcode), .d_size(d_size),
    .d_source(d_source), .d_data(d_data), .d_denied(d_denied)
);

// ==== tests/tb_soc_top.sv ====
`timescale 1ns/10ps

module tb_soc_top;

localparam int hb_half   = 8;
localparam int slow_half = 2;
localparam int n_fill    = 32;   // Words touched by the memory tests
localparam int n_mem     = 32;
localparam int max_stall = 15;
localparam int num_txn   = n_fill + 2 * n_mem + 16;
localparam int timeout_cycles = 2 * num_txn * (max_stall + 3);   // Twice the worst case

// Unmapped, but the low bits point at memory word 3
localparam logic [31:0] bad_addr [3] = '{32'h0001_000C, 32'h8000_000C, 32'h0000_040C};

logic               CLK = 1'b0;
logic               reset;
logic               a_valid;
logic               a_ready;
tl_pkg::tl_opcode_t a_opcode;
logic [2:0]         a_size;
logic [7:0]         a_source;
logic [31:0]        a_address;
logic [3:0]         a_mask;
logic [31:0]        a_data;
logic               d_valid;
logic               d_ready;
tl_pkg::tl_opcode_t d_opcode;
logic [2:0]         d_size;
logic [7:0]         d_source;
logic [31:0]        d_data;
logic               d_denied;
logic [5:0]         led;

logic [31:0] ref_mem [256];   // Expected memory contents
logic [3:0]  exp_out;
logic [7:0]  next_source = 8'd0;
integer      seed;
int          value_errors = 0;
int          protocol_errors = 0;
int          cycles = 0;
int          run_edges = 0;   // Clock edges since reset release

soc_top #(.heartbeat_half(hb_half), .slow_half(slow_half)) i_dut (
    .CLK(CLK), .reset(reset),
    .a_valid(a_valid), .a_ready(a_ready), .a_opcode(a_opcode), .a_size(a_size),
    .a_source(a_source), .a_address(a_address), .a_mask(a_mask), .a_data(a_data),
    .d_valid(d_valid), .d_ready(d_ready), .d_opcode(d_opcode), .d_size(d_size),
    .d_source(d_source), .d_data(d_data), .d_denied(d_denied),
    .led(led)
);

always #20 CLK = ~CLK;

// ========================================
// Watchdog and indicator monitor
// ========================================
always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
        $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end
end

always @(posedge CLK or posedge reset) begin
    if (reset) run_edges <= 0;
    else run_edges <= run_edges + 1;
end

always @(negedge CLK) begin
    logic exp_hb;
    logic exp_slow;
    if (!reset) begin
        exp_hb   = ((run_edges / hb_half) % 2) == 1;
        exp_slow = ((run_edges / slow_half) % 2) == 1;
        check_value("heartbeat_led", 32'(!exp_hb), 32'(led[5]));     // Active low
        check_value("slow_led", 32'(!exp_slow), 32'(led[4]));
    end
end

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    assert (actual === expected)
        else begin
            value_errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
endtask

task automatic report_error(input string msg);
    protocol_errors++;
    $display("Error: %s", msg);
endtask

// One full A/D exchange, d_ready held low for stall cycles
task automatic transact(input string name, input tl_pkg::tl_opcode_t op,
                        input logic [31:0] addr, input logic [3:0] mask,
                        input logic [31:0] wdata, input int stall, input logic hold_req,
                        output logic [31:0] rdata, output logic denied);
    logic [7:0]         src;
    logic [46:0]        held;   // Opcode, size, source, data, denied
    tl_pkg::tl_opcode_t exp_op;
    int                 i;
    src         = next_source;
    next_source = next_source + 8'd1;
    exp_op = (op == tl_pkg::op_get) ? tl_pkg::op_access_ack_data : tl_pkg::op_access_ack;
    a_valid   <= 1'b1;
    a_opcode  <= op;
    a_size    <= 3'd2;   // Whole word
    a_source  <= src;
    a_address <= addr;
    a_mask    <= mask;
    a_data    <= wdata;
    @(negedge CLK);
    while (!a_ready) @(negedge CLK);
    @(posedge CLK);   // Request taken
    if (!hold_req) a_valid <= 1'b0;   // Otherwise offered again while stalled
    @(negedge CLK);
    while (!d_valid) @(negedge CLK);
    held = {d_opcode, d_size, d_source, d_data, d_denied};
    for (i = 0; i < stall; i++) begin
        @(posedge CLK);
        @(negedge CLK);
        assert (d_valid && held == {d_opcode, d_size, d_source, d_data, d_denied})
            else report_error({name, ": response changed while d_ready was low"});
        assert (!a_ready)
            else report_error({name, ": a_ready high while a response was outstanding"});
    end
    @(posedge CLK);
    a_valid <= 1'b0;
    d_ready <= 1'b1;
    @(posedge CLK);   // D handshake
    d_ready <= 1'b0;
    check_value({name, "_opcode"}, 32'(exp_op), 32'(held[46:44]));
    check_value({name, "_size"}, 32'd2, 32'(held[43:41]));
    check_value({name, "_source"}, 32'(src), 32'(held[40:33]));
    rdata  = held[32:1];
    denied = held[0];
endtask

// ========================================
// Stimulus
// ========================================
initial begin
    logic [31:0]        r;
    logic [31:0]        rdata;
    logic [31:0]        addr;
    logic [31:0]        wdata;
    logic [7:0]         word;
    logic [3:0]         mask;
    logic               denied;
    tl_pkg::tl_opcode_t op;
    int                 total;
    seed = 32'hb677_238d;
    reset     <= 1'b1;
    a_valid   <= 1'b0;
    a_opcode  <= tl_pkg::op_get;
    a_size    <= 3'd0;
    a_source  <= 8'd0;
    a_address <= 32'd0;
    a_mask    <= 4'd0;
    a_data    <= 32'd0;
    d_ready   <= 1'b0;
    repeat (3) @(posedge CLK);
    reset <= 1'b0;
    @(negedge CLK);
    check_value("reset_a_ready", 32'd1, 32'(a_ready));
    check_value("reset_d_valid", 32'd0, 32'(d_valid));
    check_value("reset_led", 32'h3F, 32'(led));
    @(posedge CLK);

    // Known contents first, pattern spans the whole address
    for (int k = 0; k < n_fill; k++) begin
        word  = {k[4:0], 3'd3};
        addr  = {22'd0, word, 2'b00};
        wdata = {~addr[15:0], addr[15:0]};
        ref_mem[word] = wdata;
        transact("mem_fill", tl_pkg::op_put_full, addr, 4'hF, wdata, 0, 1'b0, rdata, denied);
        check_value("mem_fill_denied", 32'd0, 32'(denied));
    end

    for (int n = 0; n < n_mem; n++) begin
        r     = $random(seed);
        word  = {r[4:0], 3'd3};
        addr  = {22'd0, word, 2'b00};
        mask  = r[5] ? 4'hF : r[11:8];
        op    = r[5] ? tl_pkg::op_put_full : tl_pkg::op_put_partial;
        wdata = $random(seed);
        transact("mem_write", op, addr, mask, wdata, int'(r[14:12]), 1'b0, rdata, denied);
        check_value("mem_write_denied", 32'd0, 32'(denied));
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) ref_mem[word][8*b +: 8] = wdata[8*b +: 8];
        end
        transact("mem_read", tl_pkg::op_get, addr, 4'hF, 32'd0, int'(r[18:16]), 1'b0,
                 rdata, denied);
        check_value("mem_read_data", ref_mem[word], rdata);
        check_value("mem_read_denied", 32'd0, 32'(denied));
    end

    for (int n = 0; n < 3; n++) begin
        r    = $random(seed);
        mask = (n == 2) ? 4'b1110 : 4'b0001;   // Last write misses byte 0
        if (mask[0]) exp_out = r[3:0];
        transact("out_write", tl_pkg::op_put_partial, soc_map_pkg::out_base, mask, r, 0, 1'b0,
                 rdata, denied);
        @(negedge CLK);
        check_value("out_led", {28'd0, ~exp_out}, {28'd0, led[3:0]});
        @(posedge CLK);
        transact("out_read", tl_pkg::op_get, soc_map_pkg::out_base, 4'hF, 32'd0,
                 int'(r[6:4]), 1'b0, rdata, denied);
        check_value("out_read_data", {28'd0, exp_out}, rdata);
    end

    for (int n = 0; n < 3; n++) begin
        transact("unmapped_write", tl_pkg::op_put_full, bad_addr[n], 4'hF, 32'hDEAD_BEEF, 0,
                 1'b0, rdata, denied);
        check_value("unmapped_write_denied", 32'd1, 32'(denied));
        transact("unmapped_read", tl_pkg::op_get, bad_addr[n], 4'hF, 32'd0, 1, 1'b0,
                 rdata, denied);
        check_value("unmapped_read_denied", 32'd1, 32'(denied));
        check_value("unmapped_read_data", 32'd0, rdata);
    end
    transact("mem_after_unmapped", tl_pkg::op_get, 32'h0000_000C, 4'hF, 32'd0, 0, 1'b0,
             rdata, denied);
    check_value("mem_after_unmapped_data", ref_mem[8'd3], rdata);

    // Long stalls with the next request already waiting
    for (int n = 0; n < 3; n++) begin
        r    = $random(seed);
        word = {r[4:0], 3'd3};
        addr = {22'd0, word, 2'b00};
        transact("backpressure_read", tl_pkg::op_get, addr, 4'hF, 32'd0, 8 + int'(r[10:8]),
                 1'b1, rdata, denied);
        check_value("backpressure_data", ref_mem[word], rdata);
    end

    repeat (2) @(posedge CLK);
    total = value_errors + protocol_errors + i_dut.i_asserts.fail_count;
    $display("Errors: %0d value, %0d protocol, %0d assertion",
             value_errors, protocol_errors, i_dut.i_asserts.fail_count);
    if (total == 0) begin
        $display("*** TEST PASSED ***");
    end else begin
        $display("*** TEST FAILED ***");
    end
    $finish;
end

endmodule

// ==== flist.f ====
logic/tl_pkg.sv
logic/soc_map_pkg.sv
logic/tl_switch.sv
logic/tl_memory.sv
logic/tl_output.sv
logic/blink_timer.sv
logic/soc_top.sv
tests/soc_asserts.sv
tests/tb_soc_top.sv

// ==== Makefile ====
# Verilator build and run of the SoC bus testbench

VERILATOR ?= verilator
TOP       ?= tb_soc_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -qF '*** TEST PASSED ***' $(LOG); then echo "Simulation gave no result"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
